//--- include/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// one line of the cache.
`define LINE_WORDS      16
`define WORD_W          16

// bit index in a word, word index in the line.
`define COL_W           4

`define HOST_ADDR_W     16
`define MEM_ADDR_W      28

// ddr is addressed at 8x the word address.
`define MEM_ADDR_SHIFT  3

`endif

//--- verilog/cache_pkg.sv
`include "cache_params.svh"

package cache_pkg;

    typedef enum logic [2:0] {
        cmd_none      = 3'd0,
        cmd_row_load  = 3'd1,
        cmd_row_store = 3'd2,
        cmd_col_load  = 3'd3,
        cmd_col_store = 3'd4,
        cmd_flush     = 3'd5
    } cache_cmd_e;

    typedef struct packed {
        logic                       valid;
        cache_cmd_e                 cmd;
        logic [`HOST_ADDR_W-1:0]    addr;    // word address.
        logic [`COL_W-1:0]          col;     // bit index for column access.
        logic [`WORD_W-1:0]         wdata;   // row word or column vector.
    } host_req_t;

    typedef struct packed {
        logic                       rdy;     // one cycle per command.
        logic [`WORD_W-1:0]         rdata;
    } host_rsp_t;

    typedef struct packed {
        logic                       rd_req;
        logic                       wr_req;
        logic [`MEM_ADDR_W-1:0]     addr;
    } mem_req_t;

    // broadcast to every line word and to the gather stage.
    typedef struct packed {
        logic                       row_we;
        logic                       col_we;
        logic [`COL_W-1:0]          row_sel;
        logic [`COL_W-1:0]          col_sel;
        logic [`WORD_W-1:0]         row_data;
        logic [`WORD_W-1:0]         col_data;
        logic                       cap_row;
        logic                       cap_col;
        logic                       cap_wb;
    } word_op_t;

    typedef logic [`LINE_WORDS-1:0][`WORD_W-1:0] line_t;

endpackage

//--- verilog/cache_ctrl.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  cache_pkg::host_req_t    host_req,
    output logic                    host_rsp,    // ready pulse only.
    output cache_pkg::mem_req_t     mem_req,
    input  logic                    mem_rvalid,
    input  logic [`WORD_W-1:0]      mem_rdata,
    output logic                    mem_wvalid,
    input  logic                    mem_wready,
    output cache_pkg::word_op_t     word_op
);

    import cache_pkg::*;

    localparam int TAG_W = `HOST_ADDR_W - `COL_W;
    localparam logic [`COL_W-1:0] LAST_BEAT = `COL_W'(`LINE_WORDS - 1);

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_wb,
        st_fill,
        st_respond
    } state_e;

    state_e             state;
    logic [TAG_W-1:0]   tag;
    logic               line_valid;
    logic               dirty;
    logic [`COL_W-1:0]  beat_cnt;
    logic               wb_pend;     // beat captured, waiting on wready.

    logic [TAG_W-1:0]   req_line;
    logic [TAG_W-1:0]   mem_line;
    logic               need_line;
    logic               is_store;
    logic               hit;

    assign req_line  = host_req.addr[`HOST_ADDR_W-1:`COL_W];
    assign is_store  = (host_req.cmd == cmd_row_store) || (host_req.cmd == cmd_col_store);
    assign need_line = is_store || (host_req.cmd == cmd_row_load) ||
                       (host_req.cmd == cmd_col_load);
    assign hit       = line_valid && (tag == req_line);

    // write-back goes to the old line, fill to the requested one.
    assign mem_line = (state == st_wb) ? tag : req_line;

    always_comb
    begin
        host_rsp       = (state == st_respond);
        mem_req.rd_req = (state == st_fill);
        mem_req.wr_req = (state == st_wb);
        mem_req.addr   = `MEM_ADDR_W'({mem_line, {`COL_W{1'b0}}}) << `MEM_ADDR_SHIFT;
        mem_wvalid     = (state == st_wb) && wb_pend;
    end

    always_comb
    begin
        word_op          = '0;
        word_op.row_sel  = host_req.addr[`COL_W-1:0];
        word_op.col_sel  = host_req.col;
        word_op.row_data = host_req.wdata;
        word_op.col_data = host_req.wdata;
        case (state)
            st_lookup:
            begin
                if (hit)
                begin
                    word_op.cap_row = (host_req.cmd == cmd_row_load);
                    word_op.row_we  = (host_req.cmd == cmd_row_store);
                    word_op.cap_col = (host_req.cmd == cmd_col_load);
                    word_op.col_we  = (host_req.cmd == cmd_col_store);
                end
            end
            st_fill:
            begin
                word_op.row_sel  = beat_cnt;
                word_op.row_data = mem_rdata;
                word_op.row_we   = mem_rvalid;
            end
            st_wb:
            begin
                word_op.row_sel = beat_cnt;
                word_op.cap_wb  = !wb_pend;    // next beat only after the last was taken.
            end
            default:
            begin
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state      <= st_idle;
            tag        <= '0;
            line_valid <= 1'b0;
            dirty      <= 1'b0;
            beat_cnt   <= '0;
            wb_pend    <= 1'b0;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    if (host_req.valid)
                        state <= st_lookup;
                end
                st_lookup:
                begin
                    if (host_req.cmd == cmd_flush)
                        state <= (line_valid && dirty) ? st_wb : st_respond;
                    else if (need_line && !hit)
                        state <= (line_valid && dirty) ? st_wb : st_fill;
                    else
                    begin
                        if (is_store)
                            dirty <= 1'b1;
                        state <= st_respond;
                    end
                end
                st_wb:
                begin
                    if (!wb_pend)
                        wb_pend <= 1'b1;
                    else if (mem_wready)
                    begin
                        wb_pend  <= 1'b0;
                        beat_cnt <= beat_cnt + 1'b1;
                        if (beat_cnt == LAST_BEAT)
                        begin
                            dirty <= 1'b0;
                            state <= (host_req.cmd == cmd_flush) ? st_respond : st_fill;
                        end
                    end
                end
                st_fill:
                begin
                    if (mem_rvalid)
                    begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (beat_cnt == LAST_BEAT)
                        begin
                            tag        <= req_line;
                            line_valid <= 1'b1;
                            dirty      <= 1'b0;
                            state      <= st_lookup;    // replay as a hit.
                        end
                    end
                end
                st_respond:
                    state <= st_idle;
                default:
                    state <= st_idle;
            endcase
        end
    end

    a_no_rd_wr_overlap: assert property (@(posedge clk) disable iff (!rst)
        !(mem_req.rd_req && mem_req.wr_req));

endmodule

//--- verilog/cache_word.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_word (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`COL_W-1:0]       idx,
    input  cache_pkg::word_op_t     word_op,
    output logic [`WORD_W-1:0]      word
);

    import cache_pkg::*;

    logic row_hit;

    assign row_hit = word_op.row_we && (word_op.row_sel == idx);

    always_ff @(posedge clk)
    begin
        if (row_hit)
            word <= word_op.row_data;
        else if (word_op.col_we)
            word[word_op.col_sel] <= word_op.col_data[idx];    // own bit of the column.
    end

    // the controller never mixes both write kinds in one cycle.
    a_one_write_kind: assert property (@(posedge clk) disable iff (!rst)
        !(word_op.row_we && word_op.col_we));

endmodule

//--- verilog/cache_gather.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_gather (
    input  logic                    clk,
    input  logic                    rst,
    input  cache_pkg::word_op_t     word_op,
    input  cache_pkg::line_t        line,
    output logic [`WORD_W-1:0]      rdata,
    output logic [`WORD_W-1:0]      wb_data
);

    import cache_pkg::*;

    logic [`WORD_W-1:0] col_vec;

    // bit j comes from word j.
    always_comb
    begin
        for (int j = 0; j < `LINE_WORDS; j++)
        begin
            col_vec[j] = line[j][word_op.col_sel];
        end
    end

    always_ff @(posedge clk)
    begin
        if (word_op.cap_row)
            rdata <= line[word_op.row_sel];
        else if (word_op.cap_col)
            rdata <= col_vec;
    end

    // held stable while ddr stalls the beat.
    always_ff @(posedge clk)
    begin
        if (word_op.cap_wb)
            wb_data <= line[word_op.row_sel];
    end

    a_single_capture: assert property (@(posedge clk) disable iff (!rst)
        $onehot0({word_op.cap_row, word_op.cap_col, word_op.cap_wb}));

endmodule

//--- verilog/data_cache_top.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module data_cache_top (
    input  logic                    clk,
    input  logic                    rst,
    input  cache_pkg::host_req_t    host_req,
    output cache_pkg::host_rsp_t    host_rsp,
    output cache_pkg::mem_req_t     mem_req,
    input  logic                    mem_rvalid,
    input  logic [`WORD_W-1:0]      mem_rdata,
    output logic                    mem_wvalid,
    input  logic                    mem_wready,
    output logic [`WORD_W-1:0]      mem_wdata
);

    import cache_pkg::*;

    word_op_t   word_op;
    line_t      line;

    cache_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .host_req   (host_req),
        .host_rsp   (host_rsp.rdy),
        .mem_req    (mem_req),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .mem_wvalid (mem_wvalid),
        .mem_wready (mem_wready),
        .word_op    (word_op)
    );

    for (genvar i = 0; i < `LINE_WORDS; i++)
    begin : g_word
        cache_word u_word (
            .clk     (clk),
            .rst     (rst),
            .idx     (`COL_W'(i)),
            .word_op (word_op),
            .word    (line[i])
        );
    end

    cache_gather u_gather (
        .clk     (clk),
        .rst     (rst),
        .word_op (word_op),
        .line    (line),
        .rdata   (host_rsp.rdata),
        .wb_data (mem_wdata)
    );

endmodule

//--- dv/tb_ddr_model.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module tb_ddr_model (
    input  logic                    clk,
    input  logic                    rst,
    input  cache_pkg::mem_req_t     mem_req,
    output logic                    mem_rvalid,
    output logic [`WORD_W-1:0]      mem_rdata,
    input  logic                    mem_wvalid,
    output logic                    mem_wready,
    input  logic [`WORD_W-1:0]      mem_wdata
);

    import cache_pkg::*;

    logic [`WORD_W-1:0]         mem [0:(1 << `HOST_ADDR_W)-1];
    logic [`HOST_ADDR_W-1:0]    base;
    int                         rd_cnt;
    int                         wr_cnt;

    // ddr address back to the word address of the line.
    assign base = `HOST_ADDR_W'(mem_req.addr >> `MEM_ADDR_SHIFT);

    function automatic logic [`WORD_W-1:0] scramble(input logic [`HOST_ADDR_W-1:0] a);
        return {a[7:0], a[15:8]} ^ (a * 16'h9e37) ^ 16'h5a0f;
    endfunction

    initial
    begin
        for (int a = 0; a < (1 << `HOST_ADDR_W); a++)
            mem[a] = scramble(`HOST_ADDR_W'(a));
    end

    always @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            mem_rvalid <= 1'b0;
            mem_rdata  <= '0;
            mem_wready <= 1'b0;
            rd_cnt     <= 0;
            wr_cnt     <= 0;
        end
        else
        begin
            mem_wready <= ($urandom_range(3) != 0);    // stall about one in four.
            mem_rvalid <= 1'b0;
            if (!mem_req.rd_req)
                rd_cnt <= 0;
            else if ((rd_cnt < `LINE_WORDS) && ($urandom_range(3) != 0))
            begin
                mem_rvalid <= 1'b1;
                mem_rdata  <= mem[base + `HOST_ADDR_W'(rd_cnt)];
                rd_cnt     <= rd_cnt + 1;
            end
            if (!mem_req.wr_req)
                wr_cnt <= 0;
            else if (mem_wvalid && mem_wready)
            begin
                mem[base + `HOST_ADDR_W'(wr_cnt)] <= mem_wdata;
                wr_cnt <= wr_cnt + 1;
            end
        end
    end

endmodule

//--- dv/data_cache_tb.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module data_cache_tb;

    import cache_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int N_CMDS      = 80;
    // lookup, respond and two stalled bursts.
    localparam int MISS_CYCLES = 4 + 2 * `LINE_WORDS * 8;

    localparam logic [`HOST_ADDR_W-1:0] LINE_A = 16'h0040;
    localparam logic [`HOST_ADDR_W-1:0] LINE_B = 16'h1230;
    localparam logic [`HOST_ADDR_W-1:0] LINE_C = 16'h7e50;

    logic                   clk = 1'b0;
    logic                   rst;
    host_req_t              host_req;
    host_rsp_t              host_rsp;
    mem_req_t               mem_req;
    logic                   mem_rvalid;
    logic [`WORD_W-1:0]     mem_rdata;
    logic                   mem_wvalid;
    logic                   mem_wready;
    logic [`WORD_W-1:0]     mem_wdata;

    // shadow of memory and of the cached line.
    logic [`WORD_W-1:0]         shadow_mem [0:(1 << `HOST_ADDR_W)-1];
    logic [`WORD_W-1:0]         shadow_line [0:`LINE_WORDS-1];
    logic [`HOST_ADDR_W-1:0]    shadow_base;
    logic                       shadow_valid;
    logic                       shadow_dirty;

    logic [`WORD_W-1:0]     exp_q [$];
    bit                     chk_q [$];
    string                  test_name = "none";
    int                     n_tests = 0;
    int                     n_checks = 0;
    int                     n_errors = 0;
    int                     n_direct = 0;
    int                     n_fail = 0;
    int                     test_err_start = 0;
    int                     rd_bursts = 0;
    int                     wr_bursts = 0;
    logic                   rd_prev = 1'b0;
    logic                   wr_prev = 1'b0;

    data_cache_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .host_req   (host_req),
        .host_rsp   (host_rsp),
        .mem_req    (mem_req),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .mem_wvalid (mem_wvalid),
        .mem_wready (mem_wready),
        .mem_wdata  (mem_wdata)
    );

    tb_ddr_model ddr_i (
        .clk        (clk),
        .rst        (rst),
        .mem_req    (mem_req),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .mem_wvalid (mem_wvalid),
        .mem_wready (mem_wready),
        .mem_wdata  (mem_wdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [`WORD_W-1:0] predict(input cache_cmd_e cmd,
                                                   input logic [`HOST_ADDR_W-1:0] addr,
                                                   input logic [`COL_W-1:0] col,
                                                   input logic [`WORD_W-1:0] wdata);
        logic [`WORD_W-1:0]         result;
        logic [`HOST_ADDR_W-1:0]    base;
        logic                       miss;
        result = '0;
        base   = {addr[`HOST_ADDR_W-1:`COL_W], `COL_W'(0)};
        miss   = !shadow_valid || (shadow_base != base);
        if ((cmd == cmd_flush || miss) && shadow_valid && shadow_dirty)
        begin
            for (int k = 0; k < `LINE_WORDS; k++)
                shadow_mem[shadow_base + `HOST_ADDR_W'(k)] = shadow_line[k];
            shadow_dirty = 1'b0;
        end
        if (cmd != cmd_flush && miss)
        begin
            for (int k = 0; k < `LINE_WORDS; k++)
                shadow_line[k] = shadow_mem[base + `HOST_ADDR_W'(k)];
            shadow_base  = base;
            shadow_valid = 1'b1;
        end
        case (cmd)
            cmd_row_load:
                result = shadow_line[addr[`COL_W-1:0]];
            cmd_row_store:
            begin
                shadow_line[addr[`COL_W-1:0]] = wdata;
                shadow_dirty = 1'b1;
            end
            cmd_col_load:
                for (int j = 0; j < `LINE_WORDS; j++)
                    result[j] = shadow_line[j][col];
            cmd_col_store:
            begin
                for (int j = 0; j < `LINE_WORDS; j++)
                    shadow_line[j][col] = wdata[j];
                shadow_dirty = 1'b1;
            end
            default:
            begin
            end
        endcase
        return result;
    endfunction

    task automatic issue_cmd(input cache_cmd_e cmd, input logic [`HOST_ADDR_W-1:0] addr,
                             input logic [`COL_W-1:0] col, input logic [`WORD_W-1:0] wdata);
        host_req_t req;
        req.valid = 1'b1;
        req.cmd   = cmd;
        req.addr  = addr;
        req.col   = col;
        req.wdata = wdata;
        exp_q.push_back(predict(cmd, addr, col, wdata));
        chk_q.push_back(cmd == cmd_row_load || cmd == cmd_col_load);
        @(posedge clk);
        host_req <= req;
        @(negedge clk);
        while (!host_rsp.rdy)
            @(negedge clk);
        @(posedge clk);
        host_req <= '0;
    endtask

    task automatic expect_count(input string what, input int actual, input int expected);
        n_direct++;
        if (actual != expected)
        begin
            $display("Mismatch in %s (%s): expected %0d, actual %0d",
                     test_name, what, expected, actual);
            n_fail++;
        end
    endtask

    task automatic check_line_in_memory(input logic [`HOST_ADDR_W-1:0] base);
        logic [`HOST_ADDR_W-1:0] a;
        for (int k = 0; k < `LINE_WORDS; k++)
        begin
            a = base + `HOST_ADDR_W'(k);
            n_direct++;
            if (ddr_i.mem[a] !== shadow_mem[a])
            begin
                $display("Mismatch in %s: memory word %h expected %h, actual %h",
                         test_name, a, shadow_mem[a], ddr_i.mem[a]);
                n_fail++;
            end
        end
    endtask

    task automatic begin_test(input string name);
        test_name      = name;
        test_err_start = n_errors + n_fail;
        n_tests++;
    endtask

    task automatic end_test();
        $display("test %s finished with %0d errors", test_name,
                 n_errors + n_fail - test_err_start);
    endtask

    // one check per ready pulse.
    always @(negedge clk)
    begin
        logic [`WORD_W-1:0] exp_data;
        logic               do_check;
        if (rst && host_rsp.rdy)
        begin
            if (exp_q.size() == 0)
            begin
                $display("rdy pulsed in %s with no command outstanding", test_name);
                n_errors++;
            end
            else
            begin
                exp_data = exp_q.pop_front();
                do_check = chk_q.pop_front();
                n_checks++;
                if (do_check && (host_rsp.rdata !== exp_data))
                begin
                    $display("Mismatch in %s: expected %h, actual %h",
                             test_name, exp_data, host_rsp.rdata);
                    n_errors++;
                end
            end
        end
    end

    always @(negedge clk)
    begin
        if (mem_req.rd_req && !rd_prev)
            rd_bursts++;
        if (mem_req.wr_req && !wr_prev)
            wr_bursts++;
        rd_prev = mem_req.rd_req;
        wr_prev = mem_req.wr_req;
    end

    initial
    begin
        #((N_CMDS * MISS_CYCLES + 10) * CLK_PERIOD);
        $display("run timed out in %s before all commands finished", test_name);
        $display("CHECKS FAILED");
        $finish;
    end

    initial
    begin
        logic [`HOST_ADDR_W-1:0]    base;
        cache_cmd_e                 cmd;
        int                         rd_before;
        int                         wr_before;
        void'($urandom(41));
        rst          = 1'b0;
        host_req     = '0;
        shadow_valid = 1'b0;
        shadow_dirty = 1'b0;
        shadow_base  = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b1;
        for (int a = 0; a < (1 << `HOST_ADDR_W); a++)
            shadow_mem[a] = ddr_i.mem[a];
        @(negedge clk);

        begin_test("reset_state");
        n_direct++;
        if (host_rsp.rdy || mem_req.rd_req || mem_req.wr_req || mem_wvalid)
        begin
            $display("reset_state: an output was still high after reset");
            n_fail++;
        end
        rd_before = rd_bursts;
        issue_cmd(cmd_row_load, LINE_A | 16'h3, 4'd0, 16'h0);
        expect_count("read bursts", rd_bursts, rd_before + 1);
        end_test();

        begin_test("row_hits");
        rd_before = rd_bursts;
        issue_cmd(cmd_row_load, LINE_A | 16'h0, 4'd0, 16'h0);
        issue_cmd(cmd_row_load, LINE_A | 16'h7, 4'd0, 16'h0);
        issue_cmd(cmd_row_load, LINE_A | 16'hf, 4'd0, 16'h0);
        issue_cmd(cmd_row_load, LINE_A | 16'h9, 4'd0, 16'h0);
        expect_count("read bursts", rd_bursts, rd_before);
        end_test();

        begin_test("col_load");
        issue_cmd(cmd_col_load, LINE_A, 4'd5, 16'h0);
        issue_cmd(cmd_col_load, LINE_A | 16'h6, 4'd12, 16'h0);
        end_test();

        begin_test("store_readback");
        issue_cmd(cmd_row_store, LINE_A | 16'h4, 4'd0, 16'ha5c3);
        issue_cmd(cmd_col_store, LINE_A, 4'd2, 16'h3c96);
        issue_cmd(cmd_row_load, LINE_A | 16'h4, 4'd0, 16'h0);
        issue_cmd(cmd_col_load, LINE_A, 4'd2, 16'h0);
        issue_cmd(cmd_row_load, LINE_A | 16'h9, 4'd0, 16'h0);
        issue_cmd(cmd_col_load, LINE_A, 4'd7, 16'h0);
        end_test();

        begin_test("evict_flush");
        wr_before = wr_bursts;
        issue_cmd(cmd_row_load, LINE_B | 16'h1, 4'd0, 16'h0);    // evicts dirty line a.
        expect_count("write bursts", wr_bursts, wr_before + 1);
        check_line_in_memory(LINE_A);
        issue_cmd(cmd_row_store, LINE_B | 16'h2, 4'd0, 16'h1e2d);
        issue_cmd(cmd_flush, LINE_B, 4'd0, 16'h0);
        check_line_in_memory(LINE_B);
        wr_before = wr_bursts;
        issue_cmd(cmd_flush, LINE_B, 4'd0, 16'h0);
        expect_count("write bursts", wr_bursts, wr_before);
        end_test();

        begin_test("random_mix");
        for (int i = 0; i < 60; i++)
        begin
            case ($urandom_range(2))
                0: base = LINE_A;
                1: base = LINE_B;
                default: base = LINE_C;
            endcase
            cmd = cache_cmd_e'(3'($urandom_range(4) + 1));
            issue_cmd(cmd, base | `HOST_ADDR_W'($urandom_range(15)),
                      `COL_W'($urandom_range(15)), `WORD_W'($urandom));
        end
        issue_cmd(cmd_flush, LINE_A, 4'd0, 16'h0);
        check_line_in_memory(LINE_A);
        check_line_in_memory(LINE_B);
        check_line_in_memory(LINE_C);
        end_test();

        $display("%0d tests, %0d checks, %0d errors",
                 n_tests, n_checks + n_direct, n_errors + n_fail);
        if (n_errors + n_fail == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
verilog/cache_pkg.sv
verilog/cache_ctrl.sv
verilog/cache_word.sv
verilog/cache_gather.sv
verilog/data_cache_top.sv
dv/tb_ddr_model.sv
dv/data_cache_tb.sv

//--- Makefile
SIM = obj_dir/data_cache_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f flist.f --top-module data_cache_tb -Mdir obj_dir -o data_cache_sim

run: compile
	@./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "CHECKS FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" sim.log || { echo "simulation did not finish"; exit 1; }

clean:
	rm -rf obj_dir sim.log
